// ==== source/coef_bank_ram.sv ====
//**********************************************************
// Two-bank coefficient buffer, 64 entries per bank.
// Synchronous write, registered read with one cycle latency.
// Storage and read data come up undefined after power-on.
//**********************************************************

`include "zig_zag_config.svh"

module coef_bank_ram (
    input logic     clk,
    coef_ram_if.ram ram
);

    // Bank select is the top address bit.
    zig_zag_pkg::coef_t mem [0:2*`BLOCK_SIZE-1];

    always_ff @(posedge clk) begin
        if (ram.write_en) begin
            mem[{ram.write_bank, ram.write_addr}] <= ram.write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (ram.read_en) begin
            ram.read_data <= mem[{ram.read_bank, ram.read_addr}];  // One cycle late.
        end
    end

    //**********************************************************
    // Bank separation
    //**********************************************************

    // At full input rate the last read of a drain shares its cycle with
    // the first write of the next fill into the same bank. That write
    // goes to address 0, so it never meets the word still being read.
    property p_bank_separation;
        @(posedge clk)
        (ram.write_en && ram.read_en && (ram.write_bank == ram.read_bank))
            |-> (ram.read_addr == 6'(`BLOCK_SIZE - 1))
                && (ram.write_addr != ram.read_addr);
    endproperty

    a_bank_separation: assert property (p_bank_separation)
        else $error("Write and read collide in bank %0d.", ram.write_bank);

endmodule

// ==== source/coef_ram_if.sv ====
//**********************************************************
// Block buffer bus between the writer, the reader and the
// two-bank memory. No clock inside; the memory and both
// sides share the design clock.
//**********************************************************

interface coef_ram_if;

    // Write side, one coefficient per cycle.
    logic                      write_en;
    zig_zag_pkg::bank_t        write_bank;
    zig_zag_pkg::block_index_t write_addr;
    zig_zag_pkg::coef_t        write_data;

    // Read side. Data comes back one cycle after the address.
    logic                      read_en;
    zig_zag_pkg::bank_t        read_bank;
    zig_zag_pkg::block_index_t read_addr;
    zig_zag_pkg::coef_t        read_data;

    modport writer (
        output write_en, write_bank, write_addr, write_data
    );

    modport reader (
        output read_en, read_bank, read_addr,
        input  read_data
    );

    modport ram (
        input  write_en, write_bank, write_addr, write_data,
        input  read_en, read_bank, read_addr,
        output read_data
    );

endinterface

// ==== source/scan_reader.sv ====
//**********************************************************
// Drain side of the reorder buffer.
// Reads a full bank at addresses 0 to 63, one per cycle.
// A new block_ready may arrive on the last address of a
// drain, which gives a gapless run at full input rate.
// Outputs are registered behind the memory read register.
//**********************************************************

`include "zig_zag_config.svh"

module scan_reader (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               block_ready,
    input  zig_zag_pkg::bank_t ready_bank,
    coef_ram_if.reader         ram,
    output logic               out_valid,
    output zig_zag_pkg::coef_t out_coef,
    output logic               out_block_start
);

    localparam zig_zag_pkg::block_index_t last_index = 6'(`BLOCK_SIZE - 1);

    zig_zag_pkg::reader_state_e state;
    zig_zag_pkg::block_index_t  drain_addr;
    zig_zag_pkg::bank_t         drain_bank;
    logic                       valid_q;  // Aligned with read_data.
    logic                       start_q;

    assign ram.read_en   = (state == zig_zag_pkg::reader_draining);
    assign ram.read_addr = drain_addr;
    assign ram.read_bank = drain_bank;

    //**********************************************************
    // Drain sequencer
    //**********************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= zig_zag_pkg::reader_idle;
            drain_addr <= '0;
            drain_bank <= '0;
        end else if (block_ready) begin
            state      <= zig_zag_pkg::reader_draining;  // Restart on the new bank.
            drain_addr <= '0;
            drain_bank <= ready_bank;
        end else if (state == zig_zag_pkg::reader_draining) begin
            if (drain_addr == last_index) begin
                state <= zig_zag_pkg::reader_idle;
            end
            drain_addr <= drain_addr + 1'b1;  // Wraps back to 0.
        end
    end

    // Valid and start follow the read through the memory register
    // and then the output register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q         <= 1'b0;
            start_q         <= 1'b0;
            out_valid       <= 1'b0;
            out_block_start <= 1'b0;
        end else begin
            valid_q         <= ram.read_en;
            start_q         <= ram.read_en && (drain_addr == '0);
            out_valid       <= valid_q;
            out_block_start <= start_q;
        end
    end

    always_ff @(posedge clk) begin
        out_coef <= ram.read_data;
    end

    // A block completing before the drain reaches its last address
    // means the input ran faster than one coefficient per cycle.
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!arst_n)
        block_ready |-> (state == zig_zag_pkg::reader_idle) || (drain_addr == last_index)
    ) else $error("Input overrun, block ready at drain address %0d.", drain_addr);

endmodule

// ==== source/scan_writer.sv ====
//**********************************************************
// Fill side of the reorder buffer.
// One coefficient per in_valid cycle, no back-pressure.
// The mode is taken from inverse at the first coefficient of
// a block; changes later in the block are ignored.
//**********************************************************

`include "zig_zag_config.svh"

module scan_writer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  zig_zag_pkg::coef_t in_coef,
    input  logic               inverse,
    coef_ram_if.writer         ram,
    output logic               block_ready,
    output zig_zag_pkg::bank_t ready_bank
);

    localparam zig_zag_pkg::block_index_t last_index = 6'(`BLOCK_SIZE - 1);

    zig_zag_pkg::block_index_t position;     // Input order index.
    zig_zag_pkg::block_index_t mapped_addr;
    zig_zag_pkg::bank_t        fill_bank;
    logic                      mode_latched;
    logic                      block_mode;

    // First coefficient uses the live input, the rest use the latch.
    assign block_mode = (position == '0) ? inverse : mode_latched;

    zig_zag_map map_i (
        .inverse  (block_mode),
        .position (position),
        .address  (mapped_addr)
    );

    //**********************************************************
    // Buffer write
    //**********************************************************

    assign ram.write_en   = in_valid;
    assign ram.write_bank = fill_bank;
    assign ram.write_addr = mapped_addr;  // Reordered slot.
    assign ram.write_data = in_coef;

    // The bank that just filled is the one no longer being filled.
    assign ready_bank = ~fill_bank;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            position     <= '0;
            fill_bank    <= '0;
            mode_latched <= 1'b0;
            block_ready  <= 1'b0;
        end else begin
            block_ready <= 1'b0;
            if (in_valid) begin
                if (position == '0) begin
                    mode_latched <= inverse;
                end
                if (position == last_index) begin
                    position    <= '0;
                    fill_bank   <= ~fill_bank;  // Swap banks.
                    block_ready <= 1'b1;
                end else begin
                    position <= position + 1'b1;
                end
            end
        end
    end

    a_write_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        ram.write_en |-> !$isunknown(ram.write_addr)
    ) else $error("Write address unknown at position %0d.", position);

endmodule

// ==== source/zig_zag_config.svh ====
//**********************************************************
// Build-time constants for the coefficient reorder stage.
// COEF_WIDTH may be changed freely. The block geometry is
// fixed at 8x8 and the index tables depend on it.
//**********************************************************

`ifndef ZIG_ZAG_CONFIG_SVH
`define ZIG_ZAG_CONFIG_SVH

// Bits of one signed quantized coefficient.
`define COEF_WIDTH 12

//**********************************************************
// Block geometry
//**********************************************************

// Edge length of a block. Must stay 8 for the lookup tables.
`define BLOCK_DIM 8

// Coefficients per block.
`define BLOCK_SIZE (`BLOCK_DIM * `BLOCK_DIM)

`endif

// ==== source/zig_zag_map.sv ====
//**********************************************************
// Combinational 8x8 index map between row-major order and
// the JPEG zig-zag scan.
// inverse low  : position is row-major, address is zig-zag.
// inverse high : position is zig-zag, address is row-major.
// Row-major indices are written in octal as row_column.
//**********************************************************

`include "zig_zag_config.svh"

module zig_zag_map (
    input  logic                      inverse,
    input  zig_zag_pkg::block_index_t position,
    output zig_zag_pkg::block_index_t address
);

    //**********************************************************
    // Row-major position to zig-zag index
    //**********************************************************

    // One block row per line.
    localparam zig_zag_pkg::block_index_t rm_to_zz [0:`BLOCK_SIZE-1] = '{
        6'd0,  6'd1,  6'd5,  6'd6,  6'd14, 6'd15, 6'd27, 6'd28,  // Row 0.
        6'd2,  6'd4,  6'd7,  6'd13, 6'd16, 6'd26, 6'd29, 6'd42,  // Row 1.
        6'd3,  6'd8,  6'd12, 6'd17, 6'd25, 6'd30, 6'd41, 6'd43,  // Row 2.
        6'd9,  6'd11, 6'd18, 6'd24, 6'd31, 6'd40, 6'd44, 6'd53,  // Row 3.
        6'd10, 6'd19, 6'd23, 6'd32, 6'd39, 6'd45, 6'd52, 6'd54,  // Row 4.
        6'd20, 6'd22, 6'd33, 6'd38, 6'd46, 6'd51, 6'd55, 6'd60,  // Row 5.
        6'd21, 6'd34, 6'd37, 6'd47, 6'd50, 6'd56, 6'd59, 6'd61,  // Row 6.
        6'd35, 6'd36, 6'd48, 6'd49, 6'd57, 6'd58, 6'd62, 6'd63   // Row 7.
    };

    //**********************************************************
    // Zig-zag index to row-major position
    //**********************************************************

    // One anti-diagonal per line, in scan order.
    // The scan turns at the block edges, so the direction
    // alternates from line to line.
    localparam zig_zag_pkg::block_index_t zz_to_rm [0:`BLOCK_SIZE-1] = '{
        6'o0_0,
        6'o0_1, 6'o1_0,
        6'o2_0, 6'o1_1, 6'o0_2,
        6'o0_3, 6'o1_2, 6'o2_1, 6'o3_0,
        6'o4_0, 6'o3_1, 6'o2_2, 6'o1_3, 6'o0_4,
        6'o0_5, 6'o1_4, 6'o2_3, 6'o3_2, 6'o4_1, 6'o5_0,
        6'o6_0, 6'o5_1, 6'o4_2, 6'o3_3, 6'o2_4, 6'o1_5, 6'o0_6,
        6'o0_7, 6'o1_6, 6'o2_5, 6'o3_4, 6'o4_3, 6'o5_2, 6'o6_1, 6'o7_0,
        6'o7_1, 6'o6_2, 6'o5_3, 6'o4_4, 6'o3_5, 6'o2_6, 6'o1_7,
        6'o2_7, 6'o3_6, 6'o4_5, 6'o5_4, 6'o6_3, 6'o7_2,
        6'o7_3, 6'o6_4, 6'o5_5, 6'o4_6, 6'o3_7,
        6'o4_7, 6'o5_6, 6'o6_5, 6'o7_4,
        6'o7_5, 6'o6_6, 6'o5_7,
        6'o6_7, 6'o7_6,
        6'o7_7
    };

    //**********************************************************
    // Direction select
    //**********************************************************

    always_comb begin
        if (inverse) begin
            address = zz_to_rm[position];  // Decoder side.
        end else begin
            address = rm_to_zz[position];  // Encoder side.
        end
    end

endmodule

// ==== source/zig_zag_pkg.sv ====
//**********************************************************
// Shared types of the reorder stage.
// The index type covers one 8x8 block and is used for both
// row-major and zig-zag positions.
//**********************************************************

`include "zig_zag_config.svh"

package zig_zag_pkg;

    //**********************************************************
    // Data and address types
    //**********************************************************

    // One signed coefficient.
    typedef logic signed [`COEF_WIDTH-1:0] coef_t;

    // Position within a block, row-major or zig-zag.
    typedef logic [$clog2(`BLOCK_SIZE)-1:0] block_index_t;

    // Block buffer bank select.
    typedef logic bank_t;

    //**********************************************************
    // State machines
    //**********************************************************

    typedef enum logic {
        reader_idle,     // Waiting for a full bank.
        reader_draining  // Stepping through the 64 addresses.
    } reader_state_e;

endpackage

// ==== source/zig_zag_scanner.sv ====
//**********************************************************
// Coefficient reorder stage for 8x8 blocks.
// inverse low: row-major in, zig-zag out (encoder).
// inverse high: zig-zag in, row-major out (decoder).
// No back-pressure on either side. First output comes three
// cycles after the edge that takes the 64th input, then 64
// outputs follow back to back.
//**********************************************************

module zig_zag_scanner (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  zig_zag_pkg::coef_t in_coef,
    input  logic               inverse,
    output logic               out_valid,
    output zig_zag_pkg::coef_t out_coef,
    output logic               out_block_start
);

    logic               block_ready;  // Writer to reader handoff.
    zig_zag_pkg::bank_t ready_bank;

    coef_ram_if ram_if ();

    scan_writer writer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_coef     (in_coef),
        .inverse     (inverse),
        .ram         (ram_if.writer),
        .block_ready (block_ready),
        .ready_bank  (ready_bank)
    );

    coef_bank_ram ram_i (
        .clk (clk),
        .ram (ram_if.ram)
    );

    scan_reader reader_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .block_ready     (block_ready),
        .ready_bank      (ready_bank),
        .ram             (ram_if.reader),
        .out_valid       (out_valid),
        .out_coef        (out_coef),
        .out_block_start (out_block_start)
    );

endmodule

// ==== sources.f ====
+incdir+source
+incdir+tb
source/zig_zag_pkg.sv
source/coef_ram_if.sv
source/zig_zag_map.sv
source/coef_bank_ram.sv
source/scan_writer.sv
source/scan_reader.sv
source/zig_zag_scanner.sv
tb/tb_zig_zag_scanner.sv

// ==== tb/zig_zag_model.svh ====
//**********************************************************
// Reference model of the 8x8 zig-zag scan for the testbench.
// The scan order comes from walking the anti-diagonals, so it
// shares no table with the design. Include inside a module,
// after zig_zag_config.svh.
//**********************************************************

`ifndef ZIG_ZAG_MODEL_SVH
`define ZIG_ZAG_MODEL_SVH

typedef zig_zag_pkg::coef_t coef_block_t [0:`BLOCK_SIZE-1];

// Row-major position visited at zig-zag index k.
function automatic int zig_zag_position(input int k);
    int count;
    int s;
    int j;
    int lo;
    int hi;
    int row;
    count = 0;
    for (s = 0; s < 2 * `BLOCK_DIM - 1; s++) begin
        lo = (s < `BLOCK_DIM) ? 0 : s - (`BLOCK_DIM - 1);
        hi = (s < `BLOCK_DIM) ? s : `BLOCK_DIM - 1;
        for (j = 0; j <= hi - lo; j++) begin
            row = (s % 2 == 0) ? hi - j : lo + j;  // Even diagonals run up and right.
            if (count == k) begin
                return row * `BLOCK_DIM + (s - row);
            end
            count++;
        end
    end
    return -1;
endfunction

// Zig-zag index of row-major position rm.
function automatic int zig_zag_index(input int rm);
    int k;
    for (k = 0; k < `BLOCK_SIZE; k++) begin
        if (zig_zag_position(k) == rm) begin
            return k;
        end
    end
    return -1;
endfunction

// Output block in read order for one input block.
function automatic void expected_block(input coef_block_t in_blk, input logic inverse_mode,
                                       output coef_block_t out_blk);
    int k;
    for (k = 0; k < `BLOCK_SIZE; k++) begin
        if (inverse_mode) begin
            out_blk[k] = in_blk[zig_zag_index(k)];     // Zig-zag in, row-major out.
        end else begin
            out_blk[k] = in_blk[zig_zag_position(k)];  // Row-major in, zig-zag out.
        end
    end
endfunction

`endif

// ==== tb/tb_zig_zag_scanner.sv ====
//**********************************************************
// Testbench for the coefficient reorder stage.
// Inputs and outputs are both observed on the falling edge.
// Each completed input block queues 64 expected outputs and
// the cycle of its first output.
//**********************************************************

`include "zig_zag_config.svh"

module tb_zig_zag_scanner;

    `include "zig_zag_model.svh"

    localparam int gap_max        = 3;   // Longest idle gap between inputs.
    localparam int pause_cycles   = 20;
    localparam int num_blocks     = 12;
    localparam int stim_cycles    = 16 + pause_cycles + num_blocks * `BLOCK_SIZE * (gap_max + 1);
    localparam int timeout_cycles = 2 * stim_cycles + 200;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    zig_zag_pkg::coef_t in_coef;
    logic               inverse;
    logic               out_valid;
    zig_zag_pkg::coef_t out_coef;
    logic               out_block_start;

    int                 cycle_count;
    int                 coef_errors;
    int                 flag_errors;
    int                 latency_errors;
    int                 other_errors;
    int                 in_pos;     // Input position within the current block.
    logic               in_mode;
    int                 run_left;   // Outputs still owed by the current block.
    coef_block_t        in_blk;
    zig_zag_pkg::coef_t exp_coef_q [$];
    logic               exp_start_q [$];
    int                 exp_cycle_q [$];

    zig_zag_scanner dut_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .in_coef         (in_coef),
        .inverse         (inverse),
        .out_valid       (out_valid),
        .out_coef        (out_coef),
        .out_block_start (out_block_start)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //**********************************************************
    // Compare tasks
    //**********************************************************

    task automatic check_coef(input string name, input zig_zag_pkg::coef_t got,
                              input zig_zag_pkg::coef_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h at cycle %0d",
                     name, got, exp, cycle_count);
            coef_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h at cycle %0d",
                     name, got, exp, cycle_count);
            flag_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH %s got cycle 0x%0h expected 0x%0h", name, got, exp);
            latency_errors++;
        end
    endtask

    task automatic print_counts();
        $display("Errors: coef %0d, start flag %0d, latency %0d, other %0d",
                 coef_errors, flag_errors, latency_errors, other_errors);
    endtask

    //**********************************************************
    // Checker and input monitor
    //**********************************************************

    task automatic compare_outputs();
        if (arst_n && $isunknown(out_valid)) begin
            $display("out_valid is unknown at cycle %0d.", cycle_count);
            other_errors++;
        end else if (arst_n && out_valid) begin
            if (exp_coef_q.size() == 0) begin
                $display("out_valid high at cycle %0d with no block expected.", cycle_count);
                other_errors++;
            end else begin
                check_coef("out_coef", out_coef, exp_coef_q.pop_front());
                check_flag("out_block_start", out_block_start, exp_start_q[0]);
                if (exp_start_q.pop_front()) begin
                    check_latency("first out_valid", cycle_count, exp_cycle_q.pop_front());
                    run_left = `BLOCK_SIZE - 1;
                end else if (run_left > 0) begin
                    run_left--;
                end
            end
        end else begin
            if (arst_n) begin
                check_flag("out_block_start", out_block_start, 1'b0);  // Start only with valid.
            end
            if (run_left > 0) begin
                $display("out_valid dropped at cycle %0d with %0d outputs of a block left.",
                         cycle_count, run_left);
                other_errors++;
                run_left = 0;
            end
        end
    endtask

    task automatic capture_inputs();
        coef_block_t exp_blk;
        int          k;
        if (arst_n && in_valid === 1'b1) begin
            if (in_pos == 0) begin
                in_mode = inverse;  // Mode of the whole block.
            end
            in_blk[in_pos] = in_coef;
            in_pos++;
            if (in_pos == `BLOCK_SIZE) begin
                expected_block(in_blk, in_mode, exp_blk);
                for (k = 0; k < `BLOCK_SIZE; k++) begin
                    exp_coef_q.push_back(exp_blk[k]);
                    exp_start_q.push_back(k == 0);
                end
                // Taken at the next edge, first output three edges after that.
                exp_cycle_q.push_back(cycle_count + 4);
                in_pos = 0;
            end
        end
    endtask

    always @(negedge clk) begin
        compare_outputs();
        capture_inputs();
    end

    // Cycle counter and watchdog.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, outputs still pending.", cycle_count);
            print_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //**********************************************************
    // Stimulus
    //**********************************************************

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Pause inserts idle cycles before the last coefficient.
    task automatic send_block(input logic mode, input int max_gap, input logic toggle_mid,
                              input int pause);
        int i;
        int gap;
        for (i = 0; i < `BLOCK_SIZE; i++) begin
            if (i == `BLOCK_SIZE - 1 && pause > 0) begin
                idle_cycles(pause);
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_coef  <= zig_zag_pkg::coef_t'($urandom);
            if (i == 0) begin
                inverse <= mode;
            end else if (toggle_mid) begin
                inverse <= ~inverse;  // Must not affect this block.
            end
            gap = (i < `BLOCK_SIZE - 1) ? $urandom_range(max_gap, 0) : 0;
            if (gap > 0) begin
                idle_cycles(gap);
            end
        end
    endtask

    task automatic wait_drain();
        idle_cycles(1);
        while (exp_coef_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int b;
        int total;
        void'($urandom(26));
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_coef        = '0;
        inverse        = 1'b0;
        cycle_count    = 0;
        coef_errors    = 0;
        flag_errors    = 0;
        latency_errors = 0;
        other_errors   = 0;
        in_pos         = 0;
        run_left       = 0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        idle_cycles(10);

        // Nothing may come out while the 64th input is held back.
        send_block(1'b0, 0, 1'b0, pause_cycles);
        wait_drain();
        send_block(1'b0, 0, 1'b0, 0);  // Forward.
        wait_drain();
        send_block(1'b1, 0, 1'b0, 0);  // Inverse.
        wait_drain();

        // Full rate, alternating modes, two blocks in flight.
        for (b = 0; b < 4; b++) begin
            send_block(logic'(b % 2), 0, 1'b0, 0);
        end
        wait_drain();

        for (b = 0; b < 3; b++) begin
            send_block(logic'($urandom_range(1, 0)), gap_max, 1'b0, 0);
        end
        wait_drain();

        // Mode toggling in mid-block.
        send_block(1'b0, 1, 1'b1, 0);
        send_block(1'b1, 1, 1'b1, 0);
        wait_drain();
        idle_cycles(10);

        if (exp_coef_q.size() != 0) begin
            $display("%0d expected outputs never appeared.", exp_coef_q.size());
            other_errors++;
        end
        total = coef_errors + flag_errors + latency_errors + other_errors;
        print_counts();
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
